// File: common/cache_cfg.svh
// sets and words per line must be powers of two; a word is 32 bits with no byte enables
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// --------------------------------------------------
// data path widths
// --------------------------------------------------

// bits per data word on the processor port
`define CACHE_WORD_W 32

// word address without byte offset bits
`define CACHE_ADDR_W 30

// --------------------------------------------------
// cache geometry
// --------------------------------------------------

// sets per way with two ways fixed in the store
`define CACHE_SETS 4

// words per line, also the width of one memory transfer
`define CACHE_LINE_WORDS 4

// index, offset and tag widths are derived in cache_pkg
// line width on the memory port is LINE_WORDS * WORD_W
// the memory port moves whole lines only

`endif

// File: common/cpu_bus_pkg.sv
// port types for the word-wide processor side and the line-wide memory side; no byte enables
`include "cache_cfg.svh"

package cpu_bus_pkg;

	// --------------------------------------------------
	// basic data types
	// --------------------------------------------------

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cpu_op_e;

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	typedef logic [`CACHE_ADDR_W-1:0] word_addr_t;

	// word 0 sits in the low bits
	typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] line_t;

	// word address without the word offset
	typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_LINE_WORDS)-1:0] line_addr_t;

	// --------------------------------------------------
	// request records
	// --------------------------------------------------

	// processor request held stable until accepted
	typedef struct packed {
		cpu_op_e    op;
		word_addr_t addr;
		word_t      wdata; // ignored on reads
	} cpu_req_t;

	// memory request moving one line per transfer
	typedef struct packed {
		logic       valid;
		cpu_op_e    op;
		line_addr_t line_addr;
		line_t      data; // line to write back
	} mem_req_t;

endpackage

// File: common/cache_pkg.sv
// internal cache types; the way count is fixed at two and is not derived here
`include "cache_cfg.svh"

package cache_pkg;

	// --------------------------------------------------
	// address split
	// --------------------------------------------------

	localparam int OFFSET_W = $clog2(`CACHE_LINE_WORDS);
	localparam int INDEX_W  = $clog2(`CACHE_SETS);
	localparam int TAG_W    = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// same bit order as a word address
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} addr_fields_t;

	// --------------------------------------------------
	// controller and victim
	// --------------------------------------------------

	typedef enum logic [1:0] {
		ST_LOOKUP    = 2'd0,
		ST_WRITEBACK = 2'd1,
		ST_REFILL    = 2'd2
	} cache_state_e;

	// line that a miss on the current address would replace
	typedef struct packed {
		logic                   valid;
		cpu_bus_pkg::line_addr_t line_addr;
		cpu_bus_pkg::line_t      data;
	} victim_t;

endpackage

// File: l1_cache/cache_store.sv
// two ways with one LRU bit per set; the caller must not write and fill in the same cycle
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_store (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cpu_bus_pkg::word_addr_t i_addr,
	input  logic                    i_wr_en,
	input  cpu_bus_pkg::word_t      i_wdata,
	input  logic                    i_fill,
	input  cpu_bus_pkg::line_t      i_fill_data,
	output logic                    o_hit,
	output cpu_bus_pkg::word_t      o_rdata,
	output cache_pkg::victim_t      o_victim
);
	import cpu_bus_pkg::*;
	import cache_pkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	// per-set valid and replacement bits
	logic [`CACHE_SETS-1:0][1:0] valid_q;
	logic [`CACHE_SETS-1:0]      lru_q; // way to replace next

	// tags and lines per way
	tag_t  tag_q  [`CACHE_SETS][2];
	line_t data_q [`CACHE_SETS][2];

	addr_fields_t fields;
	logic [1:0]   way_hit;
	logic         hit_way;
	logic         victim_way;

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------

	assign fields = addr_fields_t'(i_addr);

	// full tag compare against valid ways only
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[fields.index][w] &&
				(tag_q[fields.index][w] == fields.tag);
		end
	end

	assign o_hit   = |way_hit;
	assign hit_way = way_hit[1]; // selects way 0 when nothing hits
	assign o_rdata = data_q[fields.index][hit_way][fields.offset];

	// --------------------------------------------------
	// victim selection
	// --------------------------------------------------

	// an invalid way is always the LRU one
	assign victim_way = lru_q[fields.index];

	always_comb begin
		o_victim.valid     = valid_q[fields.index][victim_way];
		o_victim.line_addr = {tag_q[fields.index][victim_way], fields.index};
		o_victim.data      = data_q[fields.index][victim_way];
	end

	// --------------------------------------------------
	// valid and replacement bits
	// --------------------------------------------------

	// a filled or hit way becomes most recently used
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			lru_q   <= '0;
		end else if (i_fill) begin
			valid_q[fields.index][victim_way] <= 1'b1;
			lru_q[fields.index]               <= ~victim_way;
		end else if (o_hit) begin
			// write hits touch the set as well
			lru_q[fields.index] <= ~hit_way;
		end
	end

	// --------------------------------------------------
	// tag and data arrays
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (i_fill) begin
			tag_q[fields.index][victim_way]  <= fields.tag;
			data_q[fields.index][victim_way] <= i_fill_data;
		end else if (i_wr_en) begin
			// write strobe only comes with a hit
			data_q[fields.index][hit_way][fields.offset] <= i_wdata;
		end
	end

	// a fill must never duplicate a tag already present in the other way
	a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		!(&way_hit))
		else $error("both ways hit in set %0d", fields.index);

endmodule

// File: l1_cache/cache_ctrl.sv
// one miss at a time; every valid victim is written back before the refill; no write buffer
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_req_valid,
	input  cpu_bus_pkg::cpu_req_t i_req,
	output logic                  o_req_ready,
	input  logic                  i_hit,
	input  cpu_bus_pkg::word_t    i_rdata,
	input  cache_pkg::victim_t    i_victim,
	output logic                  o_store_wr,
	output logic                  o_fill,
	output logic                  o_rsp_valid,
	output cpu_bus_pkg::word_t    o_rsp_rdata,
	output cpu_bus_pkg::mem_req_t o_mem_req,
	input  logic                  i_mem_ready
);
	import cpu_bus_pkg::*;
	import cache_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;
	addr_fields_t req_fields;
	line_addr_t   req_line;
	logic         accept;
	logic         rd_accept;
	logic         miss;
	logic         wb_done;
	cpu_op_e      mem_op_q;
	line_addr_t   mem_addr_q;
	line_t        mem_data_q;
	logic         rsp_valid_q;
	word_t        rsp_rdata_q;

	// --------------------------------------------------
	// handshake decode
	// --------------------------------------------------

	assign req_fields = addr_fields_t'(i_req.addr);
	assign req_line   = {req_fields.tag, req_fields.index};

	assign o_req_ready = (state_q == ST_LOOKUP) && i_req_valid && i_hit;
	assign accept      = i_req_valid && o_req_ready;
	assign rd_accept   = accept && (i_req.op == OP_READ);
	assign o_store_wr  = accept && (i_req.op == OP_WRITE);

	assign miss    = (state_q == ST_LOOKUP) && i_req_valid && !i_hit;
	assign wb_done = (state_q == ST_WRITEBACK) && i_mem_ready;
	assign o_fill  = (state_q == ST_REFILL) && i_mem_ready; // line written this edge

	// --------------------------------------------------
	// miss FSM
	// --------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_LOOKUP: begin
				if (miss) begin
					state_d = i_victim.valid ? ST_WRITEBACK : ST_REFILL;
				end
			end
			ST_WRITEBACK: begin
				if (i_mem_ready) begin
					state_d = ST_REFILL;
				end
			end
			ST_REFILL: begin
				if (i_mem_ready) begin
					state_d = ST_LOOKUP; // retried request hits next cycle
				end
			end
			default: state_d = ST_LOOKUP;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= ST_LOOKUP;
			rsp_valid_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			rsp_valid_q <= rd_accept;
		end
	end

	// --------------------------------------------------
	// memory request and response payload
	// --------------------------------------------------

	// fields load at the start of each transfer and hold until ready
	always_ff @(posedge clk) begin
		if (miss && i_victim.valid) begin
			mem_op_q   <= OP_WRITE;
			mem_addr_q <= i_victim.line_addr;
			mem_data_q <= i_victim.data;
		end else if (miss || wb_done) begin
			mem_op_q   <= OP_READ;
			mem_addr_q <= req_line;
			mem_data_q <= '0;
		end
		if (rd_accept) begin
			rsp_rdata_q <= i_rdata;
		end
	end

	// a transfer is open exactly while the FSM is out of lookup
	always_comb begin
		o_mem_req.valid     = (state_q != ST_LOOKUP);
		o_mem_req.op        = mem_op_q;
		o_mem_req.line_addr = mem_addr_q;
		o_mem_req.data      = mem_data_q;
	end

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp_rdata = rsp_rdata_q;

	// --------------------------------------------------
	// protocol checks
	// --------------------------------------------------

	a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		o_mem_req.valid && !i_mem_ready |=> $stable(o_mem_req))
		else $error("memory request changed before ready");

	// write-back and refill both work on the address still on the request port
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		i_req_valid && !o_req_ready |=> i_req_valid && $stable(i_req))
		else $error("request changed or dropped before acceptance");

endmodule

// File: l1_cache/l1_cache.sv
// two-way L1 data cache; one request at a time, read response is a one-cycle pulse without back-pressure
`timescale 1ns/1ps

module l1_cache (
	input  logic                  clk,
	input  logic                  rst_n,
	// processor side
	input  logic                  i_req_valid,
	input  cpu_bus_pkg::cpu_req_t i_req,
	output logic                  o_req_ready,
	output logic                  o_rsp_valid,
	output cpu_bus_pkg::word_t    o_rsp_rdata,
	// memory side
	output cpu_bus_pkg::mem_req_t o_mem_req,
	input  logic                  i_mem_ready,
	input  cpu_bus_pkg::line_t    i_mem_rdata
);
	import cpu_bus_pkg::*;
	import cache_pkg::*;

	// --------------------------------------------------
	// store to controller
	// --------------------------------------------------
	logic    hit;
	word_t   rdata;
	victim_t victim;
	logic    store_wr;
	logic    fill;

	// lookup runs on the request address every cycle
	cache_store store_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_addr      (i_req.addr),
		.i_wr_en     (store_wr),
		.i_wdata     (i_req.wdata),
		.i_fill      (fill),
		.i_fill_data (i_mem_rdata), // refill line lands straight from memory
		.o_hit       (hit),
		.o_rdata     (rdata),
		.o_victim    (victim)
	);

	cache_ctrl ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req_valid (i_req_valid),
		.i_req       (i_req),
		.o_req_ready (o_req_ready),
		.i_hit       (hit),
		.i_rdata     (rdata),
		.i_victim    (victim),
		.o_store_wr  (store_wr),
		.o_fill      (fill),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_mem_req   (o_mem_req),
		.i_mem_ready (i_mem_ready)
	);

endmodule

// File: test/slow_mem.sv
// behavioral line memory for simulation only; a line never written reads as word address XOR INIT_KEY
`timescale 1ns/1ps
`include "cache_cfg.svh"

module slow_mem #(
	parameter logic [31:0] INIT_KEY = 32'hc0de_5a17,
	parameter int          MAX_WAIT = 6 // longest answer latency in cycles
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_bus_pkg::mem_req_t i_mem_req,
	output logic                  o_mem_ready,
	output cpu_bus_pkg::line_t    o_mem_rdata
);
	import cpu_bus_pkg::*;

	line_t       lines [line_addr_t]; // only lines that were written back
	logic        busy;
	int unsigned wait_cnt;

	// initial content built from the full word address
	function automatic line_t read_line(input line_addr_t la);
		line_t      l;
		word_addr_t wa;
		if (lines.exists(la)) begin
			return lines[la];
		end
		for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
			wa   = word_addr_t'(la) * word_addr_t'(`CACHE_LINE_WORDS) + word_addr_t'(w);
			l[w] = word_t'(wa) ^ INIT_KEY;
		end
		return l;
	endfunction

	// --------------------------------------------------
	// request handling
	// --------------------------------------------------

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mem_ready <= 1'b0;
			o_mem_rdata <= '0;
			busy        <= 1'b0;
			wait_cnt    <= 0;
		end else if (o_mem_ready) begin
			// transfer ended at this edge
			o_mem_ready <= 1'b0;
			busy        <= 1'b0;
		end else if (!busy) begin
			if (i_mem_req.valid) begin
				busy     <= 1'b1;
				wait_cnt <= $urandom_range(MAX_WAIT - 1, 0);
			end
		end else if (wait_cnt != 0) begin
			wait_cnt <= wait_cnt - 1;
		end else begin
			o_mem_ready <= 1'b1;
			if (i_mem_req.op == OP_WRITE) begin
				lines[i_mem_req.line_addr] = i_mem_req.data; // persists for later refills
			end else begin
				o_mem_rdata <= read_line(i_mem_req.line_addr);
			end
		end
	end

endmodule

// File: test/tb_l1_cache.sv
// testbench for l1_cache; uses tags 0 to 5 only and samples DUT outputs at the falling edge
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_l1_cache;
	import cpu_bus_pkg::*;

	localparam int          OFF_W        = $clog2(`CACHE_LINE_WORDS);
	localparam int          ACCEPT_LIMIT = 200; // miss with write-back and slow memory
	localparam int          RANDOM_OPS   = 300;
	localparam logic [31:0] INIT_KEY     = 32'hc0de_5a17;
	localparam logic [31:0] SEED         = 32'h2655_28d0;

	logic     clk;
	logic     rst_n;
	logic     req_valid;
	cpu_req_t req;
	logic     req_ready;
	logic     rsp_valid;
	word_t    rsp_rdata;
	mem_req_t mem_req;
	logic     mem_ready;
	line_t    mem_rdata;

	int    data_errs;
	int    proto_errs;
	int    timeouts;
	word_t shadow [word_addr_t];    // words written so far
	bit    line_seen [line_addr_t]; // lines accessed at least once

	l1_cache l1_cache_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req_valid (req_valid),
		.i_req       (req),
		.o_req_ready (req_ready),
		.o_rsp_valid (rsp_valid),
		.o_rsp_rdata (rsp_rdata),
		.o_mem_req   (mem_req),
		.i_mem_ready (mem_ready),
		.i_mem_rdata (mem_rdata)
	);

	slow_mem #(.INIT_KEY(INIT_KEY)) mem_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mem_req   (mem_req),
		.o_mem_ready (mem_ready),
		.o_mem_rdata (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// protocol checks
	// --------------------------------------------------

	a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.valid && !mem_ready |=> mem_req.valid && $stable(mem_req))
		else begin
			proto_errs++;
			$display("memory request dropped or changed before ready");
		end

	a_rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> $past(req_valid && req_ready && (req.op == OP_READ)))
		else begin
			proto_errs++;
			$display("read response without an accepted read one cycle before");
		end

	function automatic word_addr_t make_addr(input int tag, input int index, input int offset);
		return word_addr_t'((tag * `CACHE_SETS + index) * `CACHE_LINE_WORDS + offset);
	endfunction

	// unwritten words hold the memory's address pattern
	function automatic word_t expected_word(input word_addr_t addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return word_t'(addr) ^ INIT_KEY;
	endfunction

	task automatic print_counts();
		$display("errors: data %0d, protocol %0d, timeout %0d", data_errs, proto_errs,
			timeouts);
	endtask

	task automatic check_idle_outputs(input string when);
		assert (!rsp_valid && !mem_req.valid && !req_ready) else begin
			proto_errs++;
			$display("outputs active %s", when);
		end
	endtask

	// watches the memory port until the request is accepted
	task automatic wait_for_accept(input line_addr_t la, output bit saw_mem,
		output bit saw_refill);
		int n;
		n          = 0;
		saw_mem    = 1'b0;
		saw_refill = 1'b0;
		do begin
			@(negedge clk);
			if (mem_req.valid) begin
				saw_mem = 1'b1;
			end
			if (mem_req.valid && mem_req.op == OP_READ && mem_req.line_addr == la) begin
				saw_refill = 1'b1;
			end
			n++;
		end while (!req_ready && n < ACCEPT_LIMIT);
		if (!req_ready) begin
			timeouts++;
			$display("timeout: request not accepted within %0d cycles", ACCEPT_LIMIT);
		end
	endtask

	task automatic issue_request(input cpu_op_e op, input word_addr_t addr, input word_t wdata,
		output bit saw_mem);
		bit         saw_refill;
		line_addr_t la;
		word_t      exp;
		saw_mem = 1'b0;
		if (timeouts != 0) begin
			return;
		end
		la  = addr[`CACHE_ADDR_W-1:OFF_W];
		exp = expected_word(addr);
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= '{op: op, addr: addr, wdata: wdata};
		wait_for_accept(la, saw_mem, saw_refill);
		if (timeouts != 0) begin
			return;
		end
		@(posedge clk); // accepting edge
		req_valid <= 1'b0;
		if (!line_seen.exists(la)) begin
			assert (saw_refill) else begin
				proto_errs++;
				$display("no memory read for line %h before its first access", la);
			end
			line_seen[la] = 1'b1;
		end
		if (op == OP_WRITE) begin
			shadow[addr] = wdata;
		end else begin
			@(negedge clk);
			assert (rsp_valid) else begin
				proto_errs++;
				$display("no read response in the cycle after acceptance");
			end
			assert (rsp_rdata == exp) else begin
				data_errs++;
				$display("FAIL o_rsp_rdata addr %h: got %h, expected %h", addr, rsp_rdata, exp);
			end
		end
	endtask

	// --------------------------------------------------
	// stimulus phases
	// --------------------------------------------------

	// cold miss followed by hits on the filled line
	task automatic cold_and_local_reads();
		bit saw_mem;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			issue_request(OP_READ, make_addr(0, s, 0), '0, saw_mem);
			issue_request(OP_READ, make_addr(0, s, 1), '0, saw_mem);
			assert (!saw_mem) else begin
				proto_errs++;
				$display("memory access on a read hit in set %0d", s);
			end
			issue_request(OP_WRITE, make_addr(0, s, 2), word_t'($urandom()), saw_mem);
			assert (!saw_mem) else begin
				proto_errs++;
				$display("memory access on a write hit in set %0d", s);
			end
			issue_request(OP_READ, make_addr(0, s, 2), '0, saw_mem);
		end
	endtask

	// three tags into a two-way set force write-back and refill
	task automatic eviction_reads();
		bit saw_mem;
		for (int t = 1; t <= 3; t++) begin
			issue_request(OP_WRITE, make_addr(t, 1, 3), word_t'($urandom()), saw_mem);
		end
		for (int t = 1; t <= 3; t++) begin
			issue_request(OP_READ, make_addr(t, 1, 3), '0, saw_mem);
		end
		issue_request(OP_READ, make_addr(0, 1, 2), '0, saw_mem);
	endtask

	task automatic random_traffic();
		bit      saw_mem;
		cpu_op_e op;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			op = ($urandom_range(1, 0) == 1) ? OP_WRITE : OP_READ;
			issue_request(op, make_addr($urandom_range(5, 0), $urandom_range(`CACHE_SETS - 1, 0),
				$urandom_range(`CACHE_LINE_WORDS - 1, 0)), word_t'($urandom()), saw_mem);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req        = '0;
		data_errs  = 0;
		proto_errs = 0;
		timeouts   = 0;
		repeat (8) begin
			@(negedge clk);
			check_idle_outputs("during reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle_outputs("in the first cycle after reset");
		cold_and_local_reads();
		eviction_reads();
		random_traffic();
		repeat (4) @(posedge clk);
		print_counts();
		if (data_errs == 0 && proto_errs == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
common/cpu_bus_pkg.sv
common/cache_pkg.sv
l1_cache/cache_store.sv
l1_cache/cache_ctrl.sv
l1_cache/l1_cache.sv
test/slow_mem.sv
test/tb_l1_cache.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_l1_cache \
	-Mdir "$OBJ_DIR" -o sim_tb \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
